// File: logic/ifetch_macros.svh
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// line geometry: two 32-bit words per line
`define IFETCH_OFFSET_BITS 3
`define IFETCH_INDEX_BITS 4

// pc bits above index and offset
`define IFETCH_TAG_BITS (32 - `IFETCH_OFFSET_BITS - `IFETCH_INDEX_BITS)

`define IFETCH_LINES (1 << `IFETCH_INDEX_BITS)

// first fetch address after reset
`define IFETCH_RESET_PC 32'h3000_0000

// pc[31:24] of the region that never goes through the cache
`define IFETCH_UNCACHED_TOP 8'h0f

`endif

// File: logic/ifetch_pkg.sv
`include "ifetch_macros.svh"

package ifetch_pkg;

  // upper pc bits kept per line
  typedef logic [`IFETCH_TAG_BITS-1:0] tag_t;

  // line select, pc bits just above the byte offset
  typedef logic [`IFETCH_INDEX_BITS-1:0] index_t;

  // one instruction, also one read beat
  typedef logic [31:0] word_t;

  // two words per line
  // element 0 (bits 31:0) is the lower address word
  typedef word_t [1:0] line_t;

endpackage

// File: logic/icache_array.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache_array (
  input  logic                 clock,
  input  logic                 reset,
  input  ifetch_pkg::word_t    pc,
  input  logic                 flush,
  input  logic                 fill,
  input  ifetch_pkg::line_t    fill_line,
  output logic                 hit,
  output ifetch_pkg::line_t    hit_line
);

  ifetch_pkg::index_t index;
  ifetch_pkg::tag_t   pc_tag;

  ifetch_pkg::tag_t   tags [`IFETCH_LINES];
  ifetch_pkg::line_t  data [`IFETCH_LINES];
  logic [`IFETCH_LINES-1:0] valid;

  assign index  = pc[`IFETCH_OFFSET_BITS +: `IFETCH_INDEX_BITS];
  assign pc_tag = pc[31 -: `IFETCH_TAG_BITS];

  // lookup is purely combinational on the current pc
  assign hit      = valid[index] && (tags[index] == pc_tag);
  assign hit_line = data[index];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (flush) begin
      valid <= '0; // drop every line at once
    end else if (fill) begin
      valid[index] <= 1'b1;
    end
  end

  // tag and data storage, written only on a refill
  always_ff @(posedge clock) begin
    if (fill) begin
      tags[index] <= pc_tag;
      data[index] <= fill_line;
    end
  end

endmodule

// File: logic/fetch_word_path.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module fetch_word_path (
  input  logic                 clock,
  input  ifetch_pkg::word_t    pc,
  input  ifetch_pkg::line_t    hit_line,
  input  ifetch_pkg::word_t    rdata,
  input  logic                 take_hit,
  input  logic                 take_beat,
  input  logic                 take_last,
  output ifetch_pkg::word_t    inst,
  output ifetch_pkg::line_t    refill_line
);

  logic word_sel;

  // pc bit 2 picks the upper or lower word of a line
  assign word_sel = pc[`IFETCH_OFFSET_BITS-1];

  // beat 0 sits in inst while beat 1 is on rdata
  assign refill_line = {rdata, inst};

  always_ff @(posedge clock) begin
    if (take_hit) begin
      inst <= hit_line[word_sel];
    end else if (take_beat) begin
      inst <= rdata; // inst doubles as holding register for the lower word
    end else if (take_last && word_sel) begin
      inst <= rdata; // upper word wanted, otherwise the saved beat is already right
    end
  end

endmodule

// File: logic/fetch_control.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module fetch_control (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 write_back,
  input  ifetch_pkg::word_t    npc,
  input  logic                 clear_cache,
  input  logic                 iready,
  input  logic                 arready,
  input  logic                 rvalid,
  input  logic                 rlast,
  input  logic                 hit,
  output ifetch_pkg::word_t    pc,
  output logic                 ivalid,
  output ifetch_pkg::word_t    araddr,
  output logic                 arvalid,
  output logic                 rready,
  output logic                 flush,
  output logic                 fill,
  output logic                 take_hit,
  output logic                 take_beat,
  output logic                 take_last
);

  typedef enum logic [1:0] {
    state_lookup,
    state_refill,
    state_deliver
  } state_t;

  state_t state;

  logic uncached;
  logic cached_hit;
  logic beat_ok;
  logic accept;
  logic wb_take;

  assign uncached   = (pc[31:24] == `IFETCH_UNCACHED_TOP);
  assign cached_hit = hit && !uncached;

  assign beat_ok = rready && rvalid;
  assign accept  = ivalid && iready;

  // write_back only counts when the output is not being taken this cycle
  assign wb_take = (state == state_deliver) && !accept && write_back;

  // line aligned request address
  assign araddr = {pc[31:`IFETCH_OFFSET_BITS], 1'b0, pc[`IFETCH_OFFSET_BITS-2:0]};

  always_comb begin
    take_hit  = (state == state_lookup) && cached_hit;
    take_beat = (state == state_refill) && beat_ok && !rlast;
    take_last = (state == state_refill) && beat_ok && rlast;
    fill      = take_last && !uncached; // uncached words never land in the array
    flush     = wb_take && clear_cache;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc      <= `IFETCH_RESET_PC;
      state   <= state_lookup;
      ivalid  <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      case (state)
        state_lookup: begin
          if (cached_hit) begin
            ivalid <= 1'b1;
            state  <= state_deliver;
          end else begin
            arvalid <= 1'b1; // miss or uncached
            state   <= state_refill;
          end
        end

        state_refill: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end else if (beat_ok && rlast) begin
            rready <= 1'b0;
            ivalid <= 1'b1;
            state  <= state_deliver;
          end
        end

        state_deliver: begin
          if (accept) begin
            ivalid <= 1'b0;
          end else if (wb_take) begin
            pc    <= npc;
            state <= state_lookup;
          end
        end

        default: begin
          state <= state_lookup;
        end
      endcase
    end
  end

endmodule

// File: logic/ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top (
  input  logic                 clock,
  input  logic                 reset,

  // fetch consumer side
  input  logic                 write_back,
  input  ifetch_pkg::word_t    npc,
  input  logic                 clear_cache,
  input  logic                 iready,
  output ifetch_pkg::word_t    pc,
  output ifetch_pkg::word_t    inst,
  output logic                 ivalid,

  // memory read side
  input  logic                 arready,
  input  ifetch_pkg::word_t    rdata,
  input  logic                 rvalid,
  input  logic                 rlast,
  output ifetch_pkg::word_t    araddr,
  output logic                 arvalid,
  output logic                 rready
);

  logic              hit;
  logic              flush;
  logic              fill;
  logic              take_hit;
  logic              take_beat;
  logic              take_last;
  ifetch_pkg::line_t hit_line;
  ifetch_pkg::line_t refill_line;

  fetch_control u_fetch_control (
    .clock       (clock),
    .reset       (reset),
    .write_back  (write_back),
    .npc         (npc),
    .clear_cache (clear_cache),
    .iready      (iready),
    .arready     (arready),
    .rvalid      (rvalid),
    .rlast       (rlast),
    .hit         (hit),
    .pc          (pc),
    .ivalid      (ivalid),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .rready      (rready),
    .flush       (flush),
    .fill        (fill),
    .take_hit    (take_hit),
    .take_beat   (take_beat),
    .take_last   (take_last)
  );

  icache_array u_icache_array (
    .clock     (clock),
    .reset     (reset),
    .pc        (pc),
    .flush     (flush),
    .fill      (fill),
    .fill_line (refill_line),
    .hit       (hit),
    .hit_line  (hit_line)
  );

  fetch_word_path u_fetch_word_path (
    .clock       (clock),
    .pc          (pc),
    .hit_line    (hit_line),
    .rdata       (rdata),
    .take_hit    (take_hit),
    .take_beat   (take_beat),
    .take_last   (take_last),
    .inst        (inst),
    .refill_line (refill_line)
  );

endmodule

// File: sim/burst_memory.sv
`timescale 1ns/1ps

module burst_memory (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ar_stall,
  input  logic                 r_stall,
  input  ifetch_pkg::word_t    araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output ifetch_pkg::word_t    rdata,
  output logic                 rvalid,
  output logic                 rlast,
  input  logic                 rready
);

  logic              busy;
  logic              beat; // 0 for the lower word, 1 for the upper word
  logic              hold_ar;
  logic              hold_r;
  logic              in_reset;
  ifetch_pkg::word_t base;

  // contents of the word at a byte address
  function automatic ifetch_pkg::word_t word_at(input ifetch_pkg::word_t byte_addr);
    ifetch_pkg::word_t a;
    a = {2'b00, byte_addr[31:2]};
    return (a ^ 32'h5a5a_0000) + {a[18:0], a[31:19]};
  endfunction

  initial begin
    busy    = 1'b0;
    beat    = 1'b0;
    base    = '0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rdata   = '0;
  end

  always @(posedge clock) begin
    hold_ar  = ar_stall; // stall levels from the previous cycle
    hold_r   = r_stall;
    in_reset = reset;
    if (reset) begin
      busy = 1'b0;
      beat = 1'b0;
    end else if (!busy) begin
      if (arvalid && arready) begin
        busy = 1'b1;
        beat = 1'b0;
        base = araddr;
      end
    end else if (rvalid && rready) begin
      if (rlast)
        busy = 1'b0;
      else
        beat = 1'b1;
    end

    #1;
    arready = !in_reset && !busy && !hold_ar;
    rvalid  = busy && !hold_r;
    rlast   = busy && beat;
    rdata   = busy ? word_at(base + (beat ? 32'd4 : 32'd0)) : 32'h0;
  end

endmodule

// File: sim/ifetch_tb.sv
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_tb;

  localparam int num_fetches = 400;
  localparam int wait_limit  = 300; // cycles, generous for random stalls

  logic              clock;
  logic              reset;
  logic              write_back;
  ifetch_pkg::word_t npc;
  logic              clear_cache;
  logic              iready;
  ifetch_pkg::word_t pc;
  ifetch_pkg::word_t inst;
  logic              ivalid;
  logic              arready;
  ifetch_pkg::word_t rdata;
  logic              rvalid;
  logic              rlast;
  ifetch_pkg::word_t araddr;
  logic              arvalid;
  logic              rready;
  logic              ar_stall;
  logic              r_stall;

  logic [31:0]       lcg_state;
  logic              model_valid [`IFETCH_LINES];
  ifetch_pkg::tag_t  model_tag [`IFETCH_LINES];

  always #2 clock = ~clock;

  ifetch_top u_ifetch_top (
    .clock       (clock),
    .reset       (reset),
    .write_back  (write_back),
    .npc         (npc),
    .clear_cache (clear_cache),
    .iready      (iready),
    .pc          (pc),
    .inst        (inst),
    .ivalid      (ivalid),
    .arready     (arready),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .rlast       (rlast),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .rready      (rready)
  );

  burst_memory u_burst_memory (
    .clock    (clock),
    .reset    (reset),
    .ar_stall (ar_stall),
    .r_stall  (r_stall),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .rlast    (rlast),
    .rready   (rready)
  );

  function logic [15:0] lcg_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
    logic [31:0] a;
    a = byte_addr >> 2;
    return (a ^ 32'h5a5a_0000) + {a[18:0], a[31:19]};
  endfunction

  function automatic logic is_uncached(input logic [31:0] addr);
    return addr[31:24] == `IFETCH_UNCACHED_TOP;
  endfunction

  // cached entries collide at indices 0 and 1, uncached ones reuse indices 0 and 8
  function automatic logic [31:0] pool_pc(input logic uncached, input logic [2:0] sel);
    if (uncached) begin
      case (sel[1:0])
        2'd0:    return 32'h0f00_0000;
        2'd1:    return 32'h0f00_0004;
        2'd2:    return 32'h0f00_0044;
        default: return 32'h0f00_0080;
      endcase
    end
    case (sel)
      3'd0:    return 32'h3000_0000;
      3'd1:    return 32'h3000_0004;
      3'd2:    return 32'h3000_000c;
      3'd3:    return 32'h3000_0044;
      3'd4:    return 32'h3000_0080;
      3'd5:    return 32'h3000_0084;
      3'd6:    return 32'h3100_0008;
      default: return 32'h3000_0048;
    endcase
  endfunction

  function automatic logic model_hit(input logic [31:0] addr);
    ifetch_pkg::index_t idx;
    idx = addr[`IFETCH_OFFSET_BITS +: `IFETCH_INDEX_BITS];
    return !is_uncached(addr) && model_valid[idx] &&
           (model_tag[idx] == addr[31 -: `IFETCH_TAG_BITS]);
  endfunction

  task automatic model_fill(input logic [31:0] addr);
    ifetch_pkg::index_t idx;
    idx = addr[`IFETCH_OFFSET_BITS +: `IFETCH_INDEX_BITS];
    model_valid[idx] = 1'b1;
    model_tag[idx]   = addr[31 -: `IFETCH_TAG_BITS];
  endtask

  task automatic model_clear();
    for (int i = 0; i < `IFETCH_LINES; i++)
      model_valid[i] = 1'b0;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping on timeout");
  endtask

  // one clock, then fresh memory stall levels
  task automatic step_cycle();
    logic [15:0] r;
    @(posedge clock);
    #1;
    r = lcg_random();
    ar_stall = (r[1:0] == 2'b00);
    r_stall  = (r[3:2] == 2'b00);
  endtask

  task automatic wait_delivery(input logic [31:0] exp_pc, input logic exp_hit,
                               input logic timed);
    int   edges;
    logic saw_ar;
    logic saw_r;
    logic seen;
    edges  = timed ? 1 : 0; // the write_back edge already counts
    saw_ar = 1'b0;
    saw_r  = 1'b0;
    seen   = 1'b0;
    while (!seen) begin
      step_cycle();
      edges = edges + 1;
      if (arvalid && !saw_ar)
        check_value(araddr, exp_pc & ~32'h4, "line address on araddr");
      if (rready)
        check_value(arvalid, 1'b0, "arvalid still high while rready is up");
      saw_ar = saw_ar | arvalid;
      saw_r  = saw_r | rready;
      seen   = ivalid;
      if (!seen && edges > wait_limit)
        timeout_abort("ivalid after a fetch");
    end
    check_value(saw_ar, !exp_hit, "arvalid against predicted miss");
    check_value(saw_r, !exp_hit, "rready against predicted miss");
    check_value(rready, 1'b0, "rready once ivalid is up");
    if (exp_hit && timed)
      check_value(edges, 2, "edges from write_back to ivalid on a hit");
    check_value(pc, exp_pc, "pc");
    check_value(inst, expected_word(exp_pc), "delivered inst");
  endtask

  // back-pressure, acceptance, then the write_back that moves pc
  task automatic accept_and_redirect(input logic [31:0] cur_pc, input logic [31:0] next_pc,
                                     input logic next_clear);
    logic [15:0] r;
    int          hold;
    int          gap;
    r    = lcg_random();
    hold = r % 5;
    gap  = r[7:6];
    for (int i = 0; i < hold; i++) begin
      step_cycle();
      check_value(ivalid, 1'b1, "ivalid held under back-pressure");
      check_value(inst, expected_word(cur_pc), "inst held under back-pressure");
    end
    iready = 1'b1;
    if (r[8]) begin
      write_back  = 1'b1; // lands in the accepting cycle and must be ignored
      npc         = next_pc;
      clear_cache = next_clear;
    end
    step_cycle();
    iready      = 1'b0;
    write_back  = 1'b0;
    clear_cache = 1'b0;
    check_value(ivalid, 1'b0, "ivalid after acceptance");
    check_value(pc, cur_pc, "pc after acceptance");
    for (int i = 0; i < gap; i++)
      step_cycle();
    write_back  = 1'b1;
    npc         = next_pc;
    clear_cache = next_clear;
    step_cycle();
    write_back  = 1'b0;
    clear_cache = 1'b0;
  endtask

  initial begin
    logic [15:0] r;
    logic [31:0] cur_pc;
    logic [31:0] next_pc;
    logic        next_clear;
    logic        exp_hit;
    clock       = 1'b0;
    reset       = 1'b1;
    write_back  = 1'b0;
    npc         = '0;
    clear_cache = 1'b0;
    iready      = 1'b0;
    ar_stall    = 1'b0;
    r_stall     = 1'b0;
    lcg_state   = 32'd13;
    model_clear();

    repeat (10) step_cycle();
    reset = 1'b0;

    cur_pc = `IFETCH_RESET_PC;
    wait_delivery(cur_pc, 1'b0, 1'b0);
    model_fill(cur_pc);

    for (int n = 0; n < num_fetches; n++) begin
      r          = lcg_random();
      next_pc    = pool_pc(r[1:0] == 2'b00, r[4:2]);
      next_clear = (r[9:6] == 4'd0);
      accept_and_redirect(cur_pc, next_pc, next_clear);
      if (next_clear)
        model_clear();
      exp_hit = model_hit(next_pc);
      wait_delivery(next_pc, exp_hit, 1'b1);
      if (!exp_hit && !is_uncached(next_pc))
        model_fill(next_pc);
      cur_pc = next_pc;
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: ifetch.f
+incdir+logic
logic/ifetch_pkg.sv
logic/icache_array.sv
logic/fetch_word_path.sv
logic/fetch_control.sv
logic/ifetch_top.sv
sim/burst_memory.sv
sim/ifetch_tb.sv
